// File: design/ldst_pkg.sv
//******************
// Shared geometry, address union and request record of the load/store unit
//******************
`default_nettype none

package ldst_pkg;

	// Default cache and thread geometry
	localparam int SET_NUMB_DEF    = 16;
	localparam int WAY_NUMB_DEF    = 4;
	localparam int THREAD_NUMB_DEF = 4;
	localparam int LINE_WORDS      = 4;

	// Address field widths follow the default geometry
	localparam int SET_IDX_W  = $clog2(SET_NUMB_DEF);
	localparam int WORD_IDX_W = $clog2(LINE_WORDS);
	localparam int TAG_W      = 32 - SET_IDX_W - WORD_IDX_W - 2;

	typedef logic [31:0] word_t;
	typedef word_t [LINE_WORDS-1:0] dcache_line_t;
	typedef logic [TAG_W-1:0] dcache_tag_t;
	typedef logic [$clog2(THREAD_NUMB_DEF)-1:0] thread_id_t;

	// One address word, seen raw by core and controller, split by the cache
	typedef union packed {
		word_t raw;
		struct packed {
			dcache_tag_t            tag;
			logic [SET_IDX_W-1:0]   set;
			logic [WORD_IDX_W-1:0]  word;
			logic [1:0]             offset;
		} f;
	} dcache_addr_u;

	// Request in flight of 67 bits
	typedef struct packed {
		thread_id_t   thread;
		logic         store;
		dcache_addr_u addr;
		word_t        wdata;
	} ldst_op_t;

endpackage

`default_nettype wire

// File: design/ldst_if.sv
//******************
// Internal buses between scheduler, tag stage and data stage
//******************
`default_nettype none

// Issued op from the scheduler to the tag stage
interface ldst_issue_if
	import ldst_pkg::*;
	;

	logic     valid;
	ldst_op_t op;

	modport sched (output valid, op);
	modport tag   (input valid, op);

endinterface

// Op with the tags and valid bits of all ways of its set
interface ldst_lookup_if
	import ldst_pkg::*;
	#(parameter int WAY_NUMB = WAY_NUMB_DEF);

	logic                       valid;
	ldst_op_t                   op;
	dcache_tag_t [WAY_NUMB-1:0] tags;
	logic [WAY_NUMB-1:0]        way_valid;

	modport src (output valid, op, tags, way_valid);
	modport dst (input valid, op, tags, way_valid);

endinterface

// Accepted refill written into tag and data arrays in the same cycle
interface ldst_fill_if
	import ldst_pkg::*;
	#(parameter int WAY_NUMB = WAY_NUMB_DEF);

	logic                        apply;
	logic [$clog2(WAY_NUMB)-1:0] way;
	dcache_addr_u                addr;
	dcache_line_t                line;

	modport drv   (output apply, way, addr, line);
	modport stage (input apply, way, addr, line);

endinterface

// End of an op reported by the data stage to the scheduler
interface ldst_retire_if
	import ldst_pkg::*;
	;

	logic       valid;
	thread_id_t thread;
	logic       miss;
	logic       load_hit;

	modport src   (output valid, thread, miss, load_hit);
	modport sched (input valid, thread, miss, load_hit);

endinterface

`default_nettype wire

// File: design/ldst_thread_sched.sv
//******************
// Per-thread request queues, sleep on miss and round-robin issue
//******************
`default_nettype none

module ldst_thread_sched
	import ldst_pkg::*;
#(
	parameter int THREAD_NUMB = THREAD_NUMB_DEF,
	parameter int WAY_NUMB    = WAY_NUMB_DEF,
	parameter int QUEUE_DEPTH = 4,
	parameter int CC_CREDITS  = 4
) (
	input  logic                        clk,
	input  logic                        reset,
	// Core side
	input  logic                        req_valid,
	input  thread_id_t                  req_thread,
	input  logic                        req_store,
	input  word_t                       req_addr,
	input  word_t                       req_wdata,
	output logic [THREAD_NUMB-1:0]      almost_full,
	output logic [THREAD_NUMB-1:0]      no_load_store_pending,
	// Controller side
	input  logic                        mem_credit,
	input  logic                        fill_valid,
	input  thread_id_t                  fill_thread,
	input  logic [$clog2(WAY_NUMB)-1:0] fill_way,
	input  word_t                       fill_addr,
	input  dcache_line_t                fill_line,
	output logic                        fill_ready,
	ldst_issue_if.sched                 issue,
	ldst_fill_if.drv                    fill,
	ldst_retire_if.sched                retire
);

	localparam int PTR_W  = $clog2(QUEUE_DEPTH);
	localparam int CNT_W  = $clog2(QUEUE_DEPTH + 1);
	localparam int CRED_W = $clog2(CC_CREDITS + 1);

	ldst_op_t               queue_mem [THREAD_NUMB][QUEUE_DEPTH];
	logic [PTR_W-1:0]       wr_ptr [THREAD_NUMB];
	logic [PTR_W-1:0]       rd_ptr [THREAD_NUMB];
	logic [CNT_W-1:0]       count [THREAD_NUMB];
	logic [THREAD_NUMB-1:0] asleep;
	logic [THREAD_NUMB-1:0] in_flight;
	logic [THREAD_NUMB-1:0] push;
	logic [THREAD_NUMB-1:0] pop;
	logic [THREAD_NUMB-1:0] eligible;
	logic [CRED_W-1:0]      credits;
	thread_id_t             rr_last;
	thread_id_t             grant_idx;
	logic                   grant_found;
	logic                   issue_fire;
	ldst_op_t               push_op;

	always_comb begin
		push_op.thread   = req_thread;
		push_op.store    = req_store;
		push_op.addr.raw = req_addr;
		push_op.wdata    = req_wdata;
	end

	// Queue and thread status
	always_comb begin
		for (int i = 0; i < THREAD_NUMB; i++) begin
			push[i]     = req_valid && (req_thread == thread_id_t'(i));
			pop[i]      = retire.valid && !retire.miss && (retire.thread == thread_id_t'(i));
			eligible[i] = (count[i] != '0) && !asleep[i] && !in_flight[i];
			almost_full[i] = count[i] >= CNT_W'(QUEUE_DEPTH - 1);
			no_load_store_pending[i] = (count[i] == '0) && !in_flight[i] && !asleep[i];
		end
	end

	// Round-robin pick, starting after the last granted thread
	always_comb begin
		int cand;
		grant_found = 1'b0;
		grant_idx   = rr_last;
		for (int k = 1; k <= THREAD_NUMB; k++) begin
			cand = (int'(rr_last) + k) % THREAD_NUMB;
			if (!grant_found && eligible[cand]) begin
				grant_found = 1'b1;
				grant_idx   = thread_id_t'(cand);
			end
		end
	end

	// No issue without a credit or while a refill waits
	assign issue_fire = grant_found && (credits != '0) && !fill_valid;
	assign issue.valid = issue_fire;
	assign issue.op    = queue_mem[grant_idx][rd_ptr[grant_idx]];

	assign fill_ready = fill_valid && (in_flight == '0);
	assign fill.apply = fill_ready;
	assign fill.way   = fill_way;
	assign fill.addr  = dcache_addr_u'(fill_addr);
	assign fill.line  = fill_line;

	always_ff @(posedge clk) begin
		for (int i = 0; i < THREAD_NUMB; i++) begin
			if (push[i])
				queue_mem[i][wr_ptr[i]] <= push_op;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < THREAD_NUMB; i++) begin
				wr_ptr[i] <= '0;
				rd_ptr[i] <= '0;
				count[i]  <= '0;
			end
			asleep    <= '0;
			in_flight <= '0;
			credits   <= CRED_W'(CC_CREDITS);
			rr_last   <= thread_id_t'(THREAD_NUMB - 1);
		end else begin
			for (int i = 0; i < THREAD_NUMB; i++) begin
				if (push[i])
					wr_ptr[i] <= wr_ptr[i] + 1'b1;
				if (pop[i])
					rd_ptr[i] <= rd_ptr[i] + 1'b1;
				if (push[i] && !pop[i])
					count[i] <= count[i] + 1'b1;
				else if (pop[i] && !push[i])
					count[i] <= count[i] - 1'b1;
				if (issue_fire && grant_idx == thread_id_t'(i))
					in_flight[i] <= 1'b1;
				else if (retire.valid && retire.thread == thread_id_t'(i))
					in_flight[i] <= 1'b0;
				// Sleep on a miss, wake on the refill for this thread
				if (retire.valid && retire.miss && retire.thread == thread_id_t'(i))
					asleep[i] <= 1'b1;
				else if (fill_ready && fill_thread == thread_id_t'(i))
					asleep[i] <= 1'b0;
			end
			if (issue_fire)
				rr_last <= grant_idx;
			// Load hits hand their credit straight back
			credits <= credits - CRED_W'(issue_fire)
				+ CRED_W'(retire.valid && retire.load_hit) + CRED_W'(mem_credit);
		end
	end

	// Core respects almost_full
	a_no_push_full: assert property (@(posedge clk) disable iff (reset)
		req_valid |-> count[req_thread] < CNT_W'(QUEUE_DEPTH));

	// Controller never returns more credits than it was given
	a_credit_max: assert property (@(posedge clk) disable iff (reset)
		credits <= CRED_W'(CC_CREDITS));

	// Refill only lands on an empty pipeline
	a_fill_empty_pipe: assert property (@(posedge clk) disable iff (reset)
		fill_ready |-> !retire.valid ##1 !retire.valid);

endmodule

`default_nettype wire

// File: design/ldst_tag_stage.sv
//******************
// Tag and valid arrays with the registered lookup of all ways
//******************
`default_nettype none

module ldst_tag_stage
	import ldst_pkg::*;
#(
	parameter int WAY_NUMB = WAY_NUMB_DEF,
	parameter int SET_NUMB = SET_NUMB_DEF
) (
	input  logic       clk,
	input  logic       reset,
	ldst_issue_if.tag  issue,
	ldst_lookup_if.src lookup,
	ldst_fill_if.stage fill
);

	dcache_tag_t [WAY_NUMB-1:0] tag_mem [SET_NUMB];
	logic [WAY_NUMB-1:0]        valid_mem [SET_NUMB];
	logic [SET_IDX_W-1:0]       rd_set;
	logic [SET_IDX_W-1:0]       wr_set;

	assign rd_set = issue.op.addr.f.set;
	assign wr_set = fill.addr.f.set;

	// Refill writes the tag of the chosen way
	always_ff @(posedge clk) begin
		if (fill.apply)
			tag_mem[wr_set][fill.way] <= fill.addr.f.tag;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int s = 0; s < SET_NUMB; s++)
				valid_mem[s] <= '0;
		end else if (fill.apply) begin
			valid_mem[wr_set][fill.way] <= 1'b1;
		end
	end

	// First pipeline register
	always_ff @(posedge clk) begin
		if (reset)
			lookup.valid <= 1'b0;
		else
			lookup.valid <= issue.valid;
	end

	// All ways of the set travel with the op
	always_ff @(posedge clk) begin
		if (issue.valid) begin
			lookup.op        <= issue.op;
			lookup.tags      <= tag_mem[rd_set];
			lookup.way_valid <= valid_mem[rd_set];
		end
	end

	// Set field of the address union indexes the whole array
	a_set_geometry: assert property (@(posedge clk)
		SET_NUMB == (1 << SET_IDX_W));

endmodule

`default_nettype wire

// File: design/ldst_data_stage.sv
//******************
// Data array, hit check, load select, store merge and unit outputs
//******************
`default_nettype none

module ldst_data_stage
	import ldst_pkg::*;
#(
	parameter int WAY_NUMB = WAY_NUMB_DEF,
	parameter int SET_NUMB = SET_NUMB_DEF
) (
	input  logic       clk,
	input  logic       reset,
	ldst_lookup_if.dst lookup,
	ldst_fill_if.stage fill,
	ldst_retire_if.src retire,
	// Core response
	output logic       rsp_valid,
	output thread_id_t rsp_thread,
	output logic       rsp_store,
	output word_t      rsp_data,
	// Controller request
	output logic       mem_valid,
	output logic       mem_write,
	output thread_id_t mem_thread,
	output word_t      mem_addr,
	output word_t      mem_wdata
);

	localparam int WAY_IDX_W = $clog2(WAY_NUMB);

	dcache_line_t          data_mem [SET_NUMB][WAY_NUMB];
	logic [WAY_NUMB-1:0]   hit_way;
	logic [WAY_IDX_W-1:0]  hit_idx;
	logic                  hit;
	logic                  is_store;
	logic [SET_IDX_W-1:0]  set_idx;
	logic [WORD_IDX_W-1:0] word_idx;
	word_t                 load_word;
	dcache_addr_u          line_addr;
	dcache_addr_u          word_addr;

	assign is_store = lookup.op.store;
	assign set_idx  = lookup.op.addr.f.set;
	assign word_idx = lookup.op.addr.f.word;

	// Tag compare where the lowest hitting way wins for loads
	always_comb begin
		hit_idx = '0;
		for (int w = WAY_NUMB - 1; w >= 0; w--) begin
			hit_way[w] = lookup.way_valid[w] && (lookup.tags[w] == lookup.op.addr.f.tag);
			if (hit_way[w])
				hit_idx = WAY_IDX_W'(w);
		end
	end

	assign hit       = |hit_way;
	assign load_word = data_mem[set_idx][hit_idx][word_idx];

	always_comb begin
		word_addr          = lookup.op.addr;
		word_addr.f.offset = '0;
		line_addr          = word_addr;
		line_addr.f.word   = '0;
	end

	// Refill takes the whole line; a store patches every copy that hits
	always_ff @(posedge clk) begin
		if (fill.apply) begin
			data_mem[fill.addr.f.set][fill.way] <= fill.line;
		end else if (lookup.valid && is_store) begin
			for (int w = 0; w < WAY_NUMB; w++) begin
				if (hit_way[w])
					data_mem[set_idx][w][word_idx] <= lookup.op.wdata;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rsp_valid    <= 1'b0;
			mem_valid    <= 1'b0;
			retire.valid <= 1'b0;
		end else begin
			rsp_valid    <= lookup.valid && (is_store || hit);
			mem_valid    <= lookup.valid && (is_store || !hit);
			retire.valid <= lookup.valid;
		end
	end

	// Stores go out as write-through, load misses as line reads
	always_ff @(posedge clk) begin
		if (lookup.valid) begin
			rsp_thread      <= lookup.op.thread;
			rsp_store       <= is_store;
			rsp_data        <= is_store ? lookup.op.wdata : load_word;
			mem_write       <= is_store;
			mem_thread      <= lookup.op.thread;
			mem_addr        <= is_store ? word_addr.raw : line_addr.raw;
			mem_wdata       <= lookup.op.wdata;
			retire.thread   <= lookup.op.thread;
			retire.miss     <= !is_store && !hit;
			retire.load_hit <= !is_store && hit;
		end
	end

	// A refill never meets an op in this stage, or the store merge is lost
	a_fill_idle_stage: assert property (@(posedge clk) disable iff (reset)
		fill.apply |-> !lookup.valid);

endmodule

`default_nettype wire

// File: design/load_store_unit.sv
//******************
// Load/store unit top with scheduler, tag stage and data stage
//******************
`default_nettype none

module load_store_unit
	import ldst_pkg::*;
#(
	parameter int THREAD_NUMB = THREAD_NUMB_DEF,
	parameter int WAY_NUMB    = WAY_NUMB_DEF,
	parameter int SET_NUMB    = SET_NUMB_DEF,
	parameter int QUEUE_DEPTH = 4,
	parameter int CC_CREDITS  = 4
) (
	input  logic                        clk,
	input  logic                        reset,
	// Core request
	input  logic                        req_valid,
	input  thread_id_t                  req_thread,
	input  logic                        req_store,
	input  word_t                       req_addr,
	input  word_t                       req_wdata,
	// Core response
	output logic                        rsp_valid,
	output thread_id_t                  rsp_thread,
	output logic                        rsp_store,
	output word_t                       rsp_data,
	// Controller requests
	output logic                        mem_valid,
	output logic                        mem_write,
	output thread_id_t                  mem_thread,
	output word_t                       mem_addr,
	output word_t                       mem_wdata,
	input  logic                        mem_credit,
	// Refill
	input  logic                        fill_valid,
	output logic                        fill_ready,
	input  thread_id_t                  fill_thread,
	input  logic [$clog2(WAY_NUMB)-1:0] fill_way,
	input  word_t                       fill_addr,
	input  dcache_line_t                fill_line,
	// Status per thread
	output logic [THREAD_NUMB-1:0]      almost_full,
	output logic [THREAD_NUMB-1:0]      no_load_store_pending
);

	ldst_issue_if                         issue_bus ();
	ldst_lookup_if #(.WAY_NUMB(WAY_NUMB)) lookup_bus ();
	ldst_fill_if   #(.WAY_NUMB(WAY_NUMB)) fill_bus ();
	ldst_retire_if                        retire_bus ();

	ldst_thread_sched #(
		.THREAD_NUMB (THREAD_NUMB),
		.WAY_NUMB    (WAY_NUMB),
		.QUEUE_DEPTH (QUEUE_DEPTH),
		.CC_CREDITS  (CC_CREDITS)
	) u_sched (
		.clk                   (clk),
		.reset                 (reset),
		.req_valid             (req_valid),
		.req_thread            (req_thread),
		.req_store             (req_store),
		.req_addr              (req_addr),
		.req_wdata             (req_wdata),
		.almost_full           (almost_full),
		.no_load_store_pending (no_load_store_pending),
		.mem_credit            (mem_credit),
		.fill_valid            (fill_valid),
		.fill_thread           (fill_thread),
		.fill_way              (fill_way),
		.fill_addr             (fill_addr),
		.fill_line             (fill_line),
		.fill_ready            (fill_ready),
		.issue                 (issue_bus),
		.fill                  (fill_bus),
		.retire                (retire_bus)
	);

	ldst_tag_stage #(
		.WAY_NUMB (WAY_NUMB),
		.SET_NUMB (SET_NUMB)
	) u_tag_stage (
		.clk    (clk),
		.reset  (reset),
		.issue  (issue_bus),
		.lookup (lookup_bus),
		.fill   (fill_bus)
	);

	ldst_data_stage #(
		.WAY_NUMB (WAY_NUMB),
		.SET_NUMB (SET_NUMB)
	) u_data_stage (
		.clk        (clk),
		.reset      (reset),
		.lookup     (lookup_bus),
		.fill       (fill_bus),
		.retire     (retire_bus),
		.rsp_valid  (rsp_valid),
		.rsp_thread (rsp_thread),
		.rsp_store  (rsp_store),
		.rsp_data   (rsp_data),
		.mem_valid  (mem_valid),
		.mem_write  (mem_write),
		.mem_thread (mem_thread),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata)
	);

endmodule

`default_nettype wire

// File: verif/tb_ldst.sv
//******************
// Directed testbench of the load/store unit with a controller model
//******************
`default_nettype none

module tb_ldst
	import ldst_pkg::*;
	();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int THREADS = THREAD_NUMB_DEF;
	localparam int CREDITS = 4;
	localparam int TIMEOUT = 4000;

	typedef struct packed {
		logic  store;
		word_t addr;
		word_t wdata;
	} exp_t;

	logic clk, reset;
	logic req_valid, req_store, rsp_valid, rsp_store;
	thread_id_t req_thread, rsp_thread, mem_thread, fill_thread;
	word_t req_addr, req_wdata, rsp_data, mem_addr, mem_wdata, fill_addr;
	logic mem_valid, mem_write, mem_credit, fill_valid, fill_ready;
	logic [1:0] fill_way;
	dcache_line_t fill_line;
	logic [THREADS-1:0] almost_full, no_load_store_pending;

	// Controller model and scoreboard state
	word_t mem_model [word_t];
	exp_t exp_q [THREADS][$];
	word_t fq_addr [$];
	thread_id_t fq_thread [$];
	logic [1:0] next_way [16];
	int rsp_cnt [THREADS];
	int errors, outstanding, credit_wait, credit_delay;
	int n_reads, n_writes, n_fills;
	word_t last_read_addr, last_write_addr, last_write_data;
	thread_id_t last_read_thread;
	logic hold_credits, hold_fills, fill_taken, timed_out;
	integer seed;

	load_store_unit #(.CC_CREDITS(CREDITS)) dut0 (.*);

	always #4 clk = ~clk;

	// Backing word follows an address pattern until first written
	function automatic word_t mem_read(input word_t widx);
		if (mem_model.exists(widx))
			return mem_model[widx];
		return (widx * 32'h9e3779b1) ^ 32'h0000403f;
	endfunction

	task automatic check(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("ERROR %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout: %s", what);
		errors++;
		timed_out = 1'b1;
	endtask

	always @(posedge clk)
		fill_taken <= !reset && fill_valid && fill_ready;

	always @(negedge clk) begin : ctrl_model
		exp_t e;
		word_t la;
		int s;
		if (reset) begin
			mem_credit = 1'b0;
			fill_valid = 1'b0;
		end else begin
			if (fill_taken) begin
				fill_valid = 1'b0;
				n_fills++;
			end
			mem_credit = 1'b0;
			if (!hold_credits && outstanding > 0) begin
				if (credit_wait >= credit_delay) begin
					mem_credit = 1'b1;
					outstanding--;
					credit_wait = 0;
				end else
					credit_wait++;
			end
			if (mem_valid) begin
				outstanding++;
				if (mem_write) begin
					n_writes++;
					last_write_addr = mem_addr;
					last_write_data = mem_wdata;
					mem_model[mem_addr >> 2] = mem_wdata;
					// Pending line must carry writes that land before acceptance
					if (fill_valid && mem_addr[31:4] == fill_addr[31:4])
						fill_line[mem_addr[3:2]] = mem_wdata;
				end else begin
					n_reads++;
					last_read_addr = mem_addr;
					last_read_thread = mem_thread;
					fq_addr.push_back(mem_addr);
					fq_thread.push_back(mem_thread);
				end
			end
			if (!fill_valid && !hold_fills && fq_addr.size() > 0) begin
				la = fq_addr.pop_front();
				la[3:0] = 4'b0;
				s = la[7:4];
				fill_way = next_way[s];
				next_way[s]++;
				fill_addr = la;
				fill_thread = fq_thread.pop_front();
				for (int w = 0; w < LINE_WORDS; w++)
					fill_line[w] = mem_read((la >> 2) + w);
				fill_valid = 1'b1;
			end
			check("mem_outstanding_within_credits", outstanding <= CREDITS, 1);
			// Scoreboard keeps responses in request order per thread
			if (rsp_valid) begin
				rsp_cnt[rsp_thread]++;
				if (exp_q[rsp_thread].size() == 0) begin
					$display("Response for thread %0d with no request pending", rsp_thread);
					errors++;
				end else begin
					e = exp_q[rsp_thread].pop_front();
					check("rsp_store", rsp_store, e.store);
					check("rsp_data", rsp_data, e.store ? e.wdata : mem_read(e.addr >> 2));
				end
			end
		end
	end

	task automatic push_req(input int t, input logic st, input word_t a, input word_t d);
		int n;
		exp_t e;
		n = 0;
		while (almost_full[t] && !timed_out) begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT)
				report_timeout("queue of a thread never left almost_full");
		end
		if (timed_out)
			return;
		req_valid = 1'b1;
		req_thread = thread_id_t'(t);
		req_store = st;
		req_addr = a;
		req_wdata = d;
		e = '{st, a, d};
		exp_q[t].push_back(e);
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	function automatic logic is_idle();
		for (int t = 0; t < THREADS; t++)
			if (exp_q[t].size() != 0)
				return 1'b0;
		return no_load_store_pending == '1 && !fill_valid && fq_addr.size() == 0
			&& outstanding == 0;
	endfunction

	task automatic wait_idle();
		int n;
		n = 0;
		while (!is_idle() && !timed_out) begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT)
				report_timeout("the unit never became idle");
		end
	endtask

	task automatic reset_values();
		check("rsp_valid", rsp_valid, 0);
		check("mem_valid", mem_valid, 0);
		check("fill_ready", fill_ready, 0);
		check("almost_full", almost_full, 0);
		check("no_load_store_pending", no_load_store_pending, {THREADS{1'b1}});
	endtask

	task automatic load_miss_then_store();
		int r0, f0;
		r0 = n_reads;
		push_req(0, 0, 32'h0000_5014, 0);
		wait_idle();
		check("mem_read_count", n_reads, r0 + 1);
		check("mem_addr", last_read_addr, 32'h0000_5010);
		check("mem_thread", last_read_thread, 0);
		push_req(1, 0, 32'h0000_5018, 0);
		wait_idle();
		check("mem_read_count", n_reads, r0 + 1);
		push_req(0, 1, 32'h0000_501c, 32'hcafe_0001);
		wait_idle();
		check("mem_addr", last_write_addr, 32'h0000_501c);
		check("mem_wdata", last_write_data, 32'hcafe_0001);
		push_req(2, 0, 32'h0000_501c, 0);
		// Store to an uncached line must not allocate
		r0 = n_reads;
		f0 = n_fills;
		push_req(3, 1, 32'h0000_6020, 32'hbeef_0002);
		wait_idle();
		check("fill_count", n_fills, f0);
		check("mem_read_count", n_reads, r0);
		check("mem_addr", last_write_addr, 32'h0000_6020);
		check("mem_wdata", last_write_data, 32'hbeef_0002);
		push_req(3, 0, 32'h0000_6020, 0);
		wait_idle();
	endtask

	task automatic random_threads();
		word_t r, a;
		credit_delay = 2;
		for (int i = 0; i < 200; i++) begin
			r = $random(seed);
			// Eight lines as two tags in each of four sets
			a = 32'h0000_2000 + {r[4:3], 4'b0} + {r[5], 8'b0} + {r[7:6], 2'b0};
			push_req(r[1:0], r[2], a, $random(seed));
		end
		wait_idle();
		check("no_load_store_pending", no_load_store_pending, {THREADS{1'b1}});
		credit_delay = 0;
	endtask

	task automatic credit_backpressure();
		int w0;
		w0 = n_writes;
		hold_credits = 1'b1;
		for (int i = 0; i < 8; i++)
			push_req(i % THREADS, 1, 32'h0000_8000 + i * 4, i);
		// Observation window while credits stay withheld
		repeat (40) @(negedge clk);
		check("mem_requests_without_credit", n_writes - w0, CREDITS);
		hold_credits = 1'b0;
		wait_idle();
		check("mem_requests_after_release", n_writes - w0, 8);
	endtask

	task automatic queue_status_while_asleep();
		int n, r0, c3;
		hold_fills = 1'b1;
		r0 = n_reads;
		push_req(2, 0, 32'h0000_7000, 0);
		n = 0;
		while (n_reads == r0 && !timed_out) begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT)
				report_timeout("the load miss never reached the controller");
		end
		push_req(2, 0, 32'h0000_7004, 0);
		push_req(2, 1, 32'h0000_7008, 32'h1234_5678);
		check("almost_full[2]", almost_full[2], 1);
		check("no_load_store_pending[2]", no_load_store_pending[2], 0);
		c3 = rsp_cnt[3];
		push_req(3, 1, 32'h0000_9000, 32'h0bad_f00d);
		n = 0;
		while (rsp_cnt[3] == c3 && !timed_out) begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT)
				report_timeout("another thread got no response while one slept");
		end
		hold_fills = 1'b0;
		wait_idle();
	endtask

	initial begin
		clk = 0;
		reset = 1;
		req_valid = 0;
		req_thread = '0;
		req_store = 0;
		req_addr = '0;
		req_wdata = '0;
		mem_credit = 0;
		fill_valid = 0;
		fill_thread = '0;
		fill_way = '0;
		fill_addr = '0;
		fill_line = '0;
		seed = 32'h403f;
		errors = 0;
		outstanding = 0;
		credit_wait = 0;
		credit_delay = 0;
		n_reads = 0;
		n_writes = 0;
		n_fills = 0;
		last_read_thread = '0;
		hold_credits = 0;
		hold_fills = 0;
		timed_out = 0;
		for (int s = 0; s < 16; s++)
			next_way[s] = '0;
		for (int t = 0; t < THREADS; t++)
			rsp_cnt[t] = 0;
		repeat (8) @(negedge clk);
		reset = 0;
		@(negedge clk);
		reset_values();
		load_miss_then_store();
		random_threads();
		credit_backpressure();
		queue_status_while_asleep();
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
design/ldst_pkg.sv
design/ldst_if.sv
design/ldst_thread_sched.sv
design/ldst_tag_stage.sv
design/ldst_data_stage.sv
design/load_store_unit.sv
verif/tb_ldst.sv

// File: run_sim.sh
#!/bin/bash
# Build and run the load/store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module tb_ldst -Mdir obj_dir -o sim_ldst
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/sim_ldst > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Something failed" sim.log; then
	exit 1
fi
exit 0
